//--- compile.f
+incdir+logic
logic/rf_pkg.sv
logic/register_file.sv
logic/write_arbiter.sv
logic/load_queue.sv
logic/alu_pipe.sv
logic/exec_unit_top.sv
bench/exec_unit_asserts.sv
bench/exec_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the execution unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module exec_unit_tb -f compile.f

sim_out=$(./obj_dir/Vexec_unit_tb) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

//--- bench/exec_unit_tb.sv
`timescale 1ns/1ns
`include "rf_defines.svh"

module exec_unit_tb;

    logic              clock;
    logic              arst_n;
    logic              op_strobe;
    rf_pkg::alu_op_t   op;
    logic              load_strobe;
    rf_pkg::wr_req_t   load;
    logic              load_full;
    logic              result_valid;
    rf_pkg::reg_data_t result;

    // model state always shows the DUT state after the most recent rising edge
    rf_pkg::reg_data_t model_regs [`RF_REGS];
    rf_pkg::wr_req_t   model_queue [$];
    logic              model_iss_valid;
    rf_pkg::alu_op_t   model_iss_op;
    logic              model_wb_valid;
    rf_pkg::wr_req_t   model_wb;

    logic [63:0] rng_state;
    int          errors;
    bit          aborted;
    bit          saw_full;

    exec_unit_top exec_unit_top_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .op_strobe    (op_strobe),
        .op           (op),
        .load_strobe  (load_strobe),
        .load         (load),
        .load_full    (load_full),
        .result_valid (result_valid),
        .result       (result)
    );

    always #20 clock = ~clock;

    function automatic logic [63:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic rf_pkg::alu_op_t make_op(input rf_pkg::alu_opcode_t opc,
                                                input rf_pkg::reg_addr_t rd,
                                                input rf_pkg::reg_addr_t rn,
                                                input rf_pkg::reg_addr_t rm);
        rf_pkg::alu_op_t o;
        o.opcode = opc;
        o.rd     = rd;
        o.rn     = rn;
        o.rm     = rm;
        return o;
    endfunction

    function automatic rf_pkg::alu_op_t random_op();
        logic [63:0] r;
        r = next_rand();
        return make_op(rf_pkg::alu_opcode_t'(r[2:0]), r[7:3], r[12:8], r[17:13]);
    endfunction

    function automatic rf_pkg::wr_req_t random_load(input rf_pkg::reg_addr_t addr);
        rf_pkg::wr_req_t req;
        req.addr = addr;
        req.data = next_rand();
        return req;
    endfunction

    // reference behavior of each opcode
    function automatic rf_pkg::reg_data_t alu_model(input rf_pkg::alu_opcode_t opc,
                                                    input rf_pkg::reg_data_t a,
                                                    input rf_pkg::reg_data_t b);
        case (opc)
            rf_pkg::ALU_ADD: return a + b;
            rf_pkg::ALU_SUB: return a - b;
            rf_pkg::ALU_AND: return a & b;
            rf_pkg::ALU_ORR: return a | b;
            rf_pkg::ALU_EOR: return a ^ b;
            rf_pkg::ALU_LSL: return a << b[5:0];
            rf_pkg::ALU_LSR: return a >> b[5:0];
            default:         return b;
        endcase
    endfunction

    // one rising edge: writeback wins the port, otherwise the queue head drains
    task automatic advance_model(input logic strobe, input rf_pkg::alu_op_t op_in,
                                 input logic ld, input rf_pkg::wr_req_t ld_req);
        rf_pkg::wr_req_t   w;
        logic              w_en;
        rf_pkg::reg_data_t res;
        w_en = 1'b0;
        w    = '0;
        if (model_wb_valid) begin
            w_en = 1'b1;
            w    = model_wb;
        end else if (model_queue.size() > 0) begin
            w_en = 1'b1;
            w    = model_queue.pop_front();
        end
        if (w_en && (w.addr != rf_pkg::reg_addr_t'(`RF_ZERO_REG))) begin
            model_regs[w.addr] = w.data;
        end
        // operands are read after the write, as forwarding makes them
        if (model_iss_valid) begin
            res = alu_model(model_iss_op.opcode, model_regs[model_iss_op.rn],
                            model_regs[model_iss_op.rm]);
            model_wb.addr = model_iss_op.rd;
            model_wb.data = res;
        end
        model_wb_valid  = model_iss_valid;
        model_iss_valid = strobe;
        if (strobe) begin
            model_iss_op = op_in;
        end
        if (ld) begin
            model_queue.push_back(ld_req);
        end
    endtask

    task automatic check_outputs();
        logic exp_full;
        exp_full = (model_queue.size() == `LQ_DEPTH);
        if (result_valid !== model_wb_valid) begin
            $display("ERROR at %0t ns: result_valid expected %0b actual %0b",
                     $time, model_wb_valid, result_valid);
            errors++;
        end else if (model_wb_valid && (result !== model_wb.data)) begin
            $display("ERROR at %0t ns: result expected %h actual %h",
                     $time, model_wb.data, result);
            errors++;
        end
        if (load_full !== exp_full) begin
            $display("ERROR at %0t ns: load_full expected %0b actual %0b",
                     $time, exp_full, load_full);
            errors++;
        end
        if (load_full === 1'b1) begin
            saw_full = 1'b1;
        end
    endtask

    // a load is only strobed when the DUT shows room for it
    task automatic step(input logic strobe, input rf_pkg::alu_op_t op_in,
                        input logic ld, input rf_pkg::wr_req_t ld_req);
        logic ld_go;
        if (aborted) begin
            return;
        end
        @(negedge clock);
        check_outputs();
        ld_go       = ld && (load_full !== 1'b1);
        op_strobe   = strobe;
        op          = op_in;
        load_strobe = ld_go;
        load        = ld_req;
        advance_model(strobe, op_in, ld_go, ld_req);
    endtask

    task automatic idle();
        step(1'b0, '0, 1'b0, '0);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (!aborted && (model_queue.size() != 0 || model_iss_valid || model_wb_valid)) begin
            if (cycles == 200) begin
                $display("timeout: pipeline and load queue did not drain in 200 cycles");
                errors++;
                aborted = 1'b1;
            end else begin
                idle();
                cycles++;
            end
        end
        idle();
    endtask

    task automatic load_when_free(input rf_pkg::wr_req_t req);
        int cycles;
        cycles = 0;
        while (!aborted && model_queue.size() == `LQ_DEPTH) begin
            if (cycles == 50) begin
                $display("timeout: load queue stayed full for 50 cycles");
                errors++;
                aborted = 1'b1;
            end else begin
                idle();
                cycles++;
            end
        end
        step(1'b0, '0, 1'b1, req);
    endtask

    // MOV into the zero register returns each register without changing it
    task automatic read_all_regs();
        for (int i = 0; i < `RF_REGS; i++) begin
            step(1'b1, make_op(rf_pkg::ALU_MOV, rf_pkg::reg_addr_t'(`RF_ZERO_REG),
                               '0, rf_pkg::reg_addr_t'(i)), 1'b0, '0);
        end
        wait_drain();
    endtask

    initial begin
        rf_pkg::reg_addr_t prev;
        logic [63:0]       r;
        clock       = 1'b0;
        arst_n      = 1'b0;
        op_strobe   = 1'b0;
        op          = '0;
        load_strobe = 1'b0;
        load        = '0;
        rng_state   = 64'd20333;
        errors      = 0;
        aborted     = 1'b0;
        saw_full    = 1'b0;
        for (int i = 0; i < `RF_REGS; i++) begin
            model_regs[i] = '0;
        end
        model_iss_valid = 1'b0;
        model_iss_op    = '0;
        model_wb_valid  = 1'b0;
        model_wb        = '0;
        repeat (16) @(negedge clock);
        arst_n = 1'b1;

        // every register ORed with the zero register reads back zero
        for (int i = 0; i < `RF_REGS; i++) begin
            step(1'b1, make_op(rf_pkg::ALU_ORR, rf_pkg::reg_addr_t'(i), rf_pkg::reg_addr_t'(i),
                               rf_pkg::reg_addr_t'(`RF_ZERO_REG)), 1'b0, '0);
        end
        wait_drain();

        for (int i = 0; i < `RF_REGS; i++) begin
            load_when_free(random_load(rf_pkg::reg_addr_t'(i)));
        end
        wait_drain();
        read_all_regs();

        for (int n = 0; n < 300; n++) begin
            r = next_rand();
            step(r[0] | r[1], random_op(), 1'b0, '0);
        end
        wait_drain();

        // each op reads the register that the previous one writes
        prev = next_rand() >> 59;
        for (int n = 0; n < 40; n++) begin
            r = next_rand();
            step(1'b1, make_op(rf_pkg::alu_opcode_t'(r[2:0]), r[7:3], prev, r[12:8]), 1'b0, '0);
            prev = r[7:3];
        end
        wait_drain();

        saw_full = 1'b0;
        for (int n = 0; n < 24; n++) begin
            step(1'b1, random_op(), model_queue.size() < `LQ_DEPTH,
                 random_load(next_rand() >> 59));
        end
        if (!saw_full && !aborted) begin
            $display("load_full never rose while writebacks held the write port");
            errors++;
        end
        wait_drain();
        read_all_regs();

        for (int n = 0; n < 2000; n++) begin
            r = next_rand();
            step(r[1:0] != 2'b00, random_op(), (r[3:2] == 2'b00) && (model_queue.size() < `LQ_DEPTH),
                 random_load(r[12:8]));
        end
        wait_drain();
        read_all_regs();

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- bench/exec_unit_asserts.sv
`timescale 1ns/1ns
`include "rf_defines.svh"

module exec_unit_asserts (
    input logic              clock,
    input logic              arst_n,
    input logic              wb_valid,
    input logic              lq_valid,
    input logic              lq_pop,
    input logic              wr_en,
    input logic              load_strobe,
    input logic              load_full,
    input rf_pkg::reg_addr_t select_a,
    input rf_pkg::reg_data_t out_a
);

    write_port_busy: assert property (@(posedge clock) disable iff (!arst_n)
        (wb_valid || lq_valid) |-> wr_en)
        else $error("write port left idle while a writer was waiting");

    // the queue only drains in a cycle without writeback
    pop_yields: assert property (@(posedge clock) disable iff (!arst_n)
        wb_valid |-> !lq_pop)
        else $error("load queue popped while writeback held the port");

    no_push_full: assert property (@(posedge clock) disable iff (!arst_n)
        load_full |-> !load_strobe)
        else $error("load pushed while the queue was full");

    zero_reg_reads: assert property (@(posedge clock) disable iff (!arst_n)
        (select_a == rf_pkg::reg_addr_t'(`RF_ZERO_REG)) |-> (out_a == '0))
        else $error("zero register read back a nonzero value");

endmodule

bind exec_unit_top exec_unit_asserts exec_unit_asserts_inst (
    .clock       (clock),
    .arst_n      (arst_n),
    .wb_valid    (wb_valid),
    .lq_valid    (lq_valid),
    .lq_pop      (lq_pop),
    .wr_en       (wr_en),
    .load_strobe (load_strobe),
    .load_full   (load_full),
    .select_a    (rd_addr_a),
    .out_a       (rd_data_a)
);

//--- logic/exec_unit_top.sv
`timescale 1ns/1ns

module exec_unit_top (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              op_strobe,
    input  rf_pkg::alu_op_t   op,
    input  logic              load_strobe,
    input  rf_pkg::wr_req_t   load,
    output logic              load_full,
    output logic              result_valid,
    output rf_pkg::reg_data_t result
);

    rf_pkg::reg_addr_t rd_addr_a;
    rf_pkg::reg_addr_t rd_addr_b;
    rf_pkg::reg_data_t rd_data_a;
    rf_pkg::reg_data_t rd_data_b;
    logic              wb_valid;
    rf_pkg::wr_req_t   wb;
    logic              lq_valid;
    rf_pkg::wr_req_t   lq_head;
    logic              lq_pop;
    logic              wr_en;
    rf_pkg::wr_req_t   wr;

    alu_pipe alu_pipe_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .op_strobe    (op_strobe),
        .op           (op),
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .result_valid (result_valid),
        .result       (result)
    );

    load_queue load_queue_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .push       (load_strobe),
        .push_req   (load),
        .pop        (lq_pop),
        .head_valid (lq_valid),
        .head       (lq_head),
        .full       (load_full)
    );

    write_arbiter write_arbiter_inst (
        .wb_valid (wb_valid),
        .wb       (wb),
        .lq_valid (lq_valid),
        .lq_head  (lq_head),
        .lq_pop   (lq_pop),
        .wr_en    (wr_en),
        .wr       (wr)
    );

    register_file register_file_inst (
        .clock    (clock),
        .arst_n   (arst_n),
        .select_a (rd_addr_a),
        .select_b (rd_addr_b),
        .out_a    (rd_data_a),
        .out_b    (rd_data_b),
        .wr_en    (wr_en),
        .wr       (wr)
    );

endmodule

//--- logic/alu_pipe.sv
`timescale 1ns/1ns

module alu_pipe (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              op_strobe,
    input  rf_pkg::alu_op_t   op,
    output rf_pkg::reg_addr_t rd_addr_a,
    output rf_pkg::reg_addr_t rd_addr_b,
    input  rf_pkg::reg_data_t rd_data_a,
    input  rf_pkg::reg_data_t rd_data_b,
    output logic              wb_valid,
    output rf_pkg::wr_req_t   wb,
    output logic              result_valid,
    output rf_pkg::reg_data_t result
);

    logic              issue_valid;
    rf_pkg::alu_op_t   issue_op;
    rf_pkg::shamt_t    shamt;
    rf_pkg::reg_data_t exec_result;

    // issue stage
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= op_strobe;
        end
    end

    always_ff @(posedge clock) begin
        if (op_strobe) begin
            issue_op <= op;
        end
    end

    assign rd_addr_a = issue_op.rn;
    assign rd_addr_b = issue_op.rm;

    assign shamt = rd_data_b[$bits(rf_pkg::shamt_t)-1:0]; // low 6 bits of rm

    // execute, in the same cycle as the operand read
    always_comb begin
        case (issue_op.opcode)
            rf_pkg::ALU_ADD: exec_result = rd_data_a + rd_data_b;
            rf_pkg::ALU_SUB: exec_result = rd_data_a - rd_data_b;
            rf_pkg::ALU_AND: exec_result = rd_data_a & rd_data_b;
            rf_pkg::ALU_ORR: exec_result = rd_data_a | rd_data_b;
            rf_pkg::ALU_EOR: exec_result = rd_data_a ^ rd_data_b;
            rf_pkg::ALU_LSL: exec_result = rd_data_a << shamt;
            rf_pkg::ALU_LSR: exec_result = rd_data_a >> shamt;
            rf_pkg::ALU_MOV: exec_result = rd_data_b;
            default:         exec_result = '0;
        endcase
    end

    // writeback stage, feeds both the arbiter and the host
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            wb.addr <= issue_op.rd;
            wb.data <= exec_result;
        end
    end

    assign result_valid = wb_valid;
    assign result       = wb.data;

endmodule

//--- logic/load_queue.sv
`timescale 1ns/1ns
`include "rf_defines.svh"

module load_queue (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              push,
    input  rf_pkg::wr_req_t   push_req,
    input  logic              pop,
    output logic              head_valid,
    output rf_pkg::wr_req_t   head,
    output logic              full
);

    rf_pkg::wr_req_t   entries [`LQ_DEPTH];
    rf_pkg::lq_ptr_t   wr_ptr;
    rf_pkg::lq_ptr_t   rd_ptr;
    rf_pkg::lq_count_t count;
    logic              do_push;
    logic              do_pop;

    assign head_valid = (count != '0);
    assign full       = (count == rf_pkg::lq_count_t'(`LQ_DEPTH));
    assign head       = entries[rd_ptr];

    assign do_push = push && !full; // host keeps off push while full anyway
    assign do_pop  = pop && head_valid;

    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    // depth is a power of two so the pointers wrap by themselves
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count; // both or neither leave the level alone
                end
            endcase
        end
    end

endmodule

//--- logic/write_arbiter.sv
`timescale 1ns/1ns

module write_arbiter (
    input  logic            wb_valid,
    input  rf_pkg::wr_req_t wb,
    input  logic            lq_valid,
    input  rf_pkg::wr_req_t lq_head,
    output logic            lq_pop,
    output logic            wr_en,
    output rf_pkg::wr_req_t wr
);

    // the pipeline cannot stall, so its writeback always wins
    // and the load queue only gets the port in an idle cycle

    always_comb begin
        lq_pop = lq_valid && !wb_valid;
        wr_en  = wb_valid || lq_valid;
        if (wb_valid) begin
            wr = wb;
        end else begin
            wr = lq_head; // don't care when lq_valid is low too
        end
    end

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ns
`include "rf_defines.svh"

module register_file (
    input  logic              clock,
    input  logic              arst_n,
    input  rf_pkg::reg_addr_t select_a,
    input  rf_pkg::reg_addr_t select_b,
    output rf_pkg::reg_data_t out_a,
    output rf_pkg::reg_data_t out_b,
    input  logic              wr_en,
    input  rf_pkg::wr_req_t   wr
);

    // register 31 has no storage, only 0 to 30 are real
    rf_pkg::reg_data_t regs [`RF_REGS-1];
    logic              wr_live;

    assign wr_live = wr_en && (wr.addr != rf_pkg::reg_addr_t'(`RF_ZERO_REG));

    // one read port: zero register, then same-cycle write, then the array
    function automatic rf_pkg::reg_data_t read_port(input rf_pkg::reg_addr_t sel);
        if (sel == rf_pkg::reg_addr_t'(`RF_ZERO_REG)) begin
            return '0;
        end
        if (wr_live && (wr.addr == sel)) begin
            return wr.data; // forward so a dependent op sees the new value
        end
        return regs[sel];
    endfunction

    always_comb begin
        out_a = read_port(select_a);
    end

    always_comb begin
        out_b = read_port(select_b);
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RF_REGS-1; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr.addr] <= wr.data;
        end
    end

endmodule

//--- logic/rf_pkg.sv
`include "rf_defines.svh"

package rf_pkg;

    typedef logic [`RF_DATA_W-1:0]           reg_data_t;
    typedef logic [$clog2(`RF_REGS)-1:0]     reg_addr_t;
    typedef logic [$clog2(`RF_DATA_W)-1:0]   shamt_t;    // shift amount taken from rm
    typedef logic [$clog2(`LQ_DEPTH)-1:0]    lq_ptr_t;
    typedef logic [$clog2(`LQ_DEPTH+1)-1:0]  lq_count_t; // holds 0 up to a full queue

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_ORR = 3'd3,
        ALU_EOR = 3'd4,
        ALU_LSL = 3'd5,
        ALU_LSR = 3'd6,
        ALU_MOV = 3'd7
    } alu_opcode_t;

    // one register-to-register operation from the host
    typedef struct packed {
        alu_opcode_t opcode;
        reg_addr_t   rd;
        reg_addr_t   rn;
        reg_addr_t   rm;
    } alu_op_t;

    // a register write, used for loads and for ALU writeback alike
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } wr_req_t;

endpackage

//--- logic/rf_defines.svh
`ifndef RF_DEFINES_SVH
`define RF_DEFINES_SVH

// register file geometry
`define RF_DATA_W   64
`define RF_REGS     32

`define RF_ZERO_REG 31  // reads as zero, writes are dropped

// pending loads waiting for a free write port
`define LQ_DEPTH    4

`endif
